// ==== axi_lite_pkg.sv ====
// Bus-side types for the AXI4-Lite read port of the cache.

package axi_lite_pkg;

    typedef logic [63:0] axi_addr_t;
    typedef logic [63:0] axi_data_t;
    typedef logic [1:0]  axi_resp_t;  // OKAY, EXOKAY, SLVERR, DECERR.

endpackage

// ==== icache.f ====
+incdir+.
icache_pkg.sv
axi_lite_pkg.sv
icache_way.sv
icache_ctrl.sv
icache_axi_read.sv
icache_top.sv
tb_icache_asserts.sv
tb_icache.sv

// ==== icache_axi_read.sv ====
// AXI4-Lite read master for cache refills.
// A rising refill request starts one AR/R transaction; the single R beat
// comes back as the line together with a one-cycle done pulse.

`timescale 1ns/10ps

module icache_axi_read (
    input  logic                    clk,
    input  logic                    i_rst_n,
    input  logic                    i_req,
    input  axi_lite_pkg::axi_addr_t i_req_addr,
    output logic                    o_done,
    output icache_pkg::line_t       o_line,
    output logic                    o_arvalid,
    output axi_lite_pkg::axi_addr_t o_araddr,
    output logic [2:0]              o_arprot,
    input  logic                    i_arready,
    input  logic                    i_rvalid,
    input  axi_lite_pkg::axi_data_t i_rdata,
    input  axi_lite_pkg::axi_resp_t i_rresp,  // not checked, instruction fetch has no fault path.
    output logic                    o_rready
);

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA
    } rd_state_t;

    rd_state_t state;
    logic      req_q;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state  <= RD_IDLE;
            req_q  <= 1'b0;
            o_done <= 1'b0;
        end else begin
            req_q  <= i_req;
            o_done <= 1'b0;
            case (state)
                RD_IDLE: if (i_req && !req_q) state <= RD_ADDR;  // rising edge only.
                RD_ADDR: if (i_arready) state <= RD_DATA;
                RD_DATA: begin
                    if (i_rvalid) begin
                        state  <= RD_IDLE;
                        o_done <= 1'b1;
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == RD_IDLE) && i_req && !req_q)
            o_araddr <= i_req_addr;
        if ((state == RD_DATA) && i_rvalid)
            o_line <= i_rdata;
    end

    assign o_arvalid = (state == RD_ADDR);
    assign o_arprot  = 3'b000;  // unprivileged, secure, data.
    assign o_rready  = (state == RD_DATA);

endmodule

// ==== icache_consts.svh ====
// Size and timing constants for the two-way instruction cache.
// Included by the cache package and by any module that sizes arrays.

`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

`define ICACHE_ADDR_W   64
`define ICACHE_SETS     64
`define ICACHE_INDEX_W  6
`define ICACHE_TAG_W    55  // address bits 63 to 9.
`define ICACHE_LINE_W   64
`define ICACHE_INST_W   32

// 3-bit saturating replacement age.
`define ICACHE_AGE_W    3
`define ICACHE_AGE_MAX  7

// cycles from fetch accept to o_inst_valid on a hit.
`define ICACHE_HIT_LAT  2

`endif

// ==== icache_ctrl.sv ====
// Lookup controller for the two-way instruction cache.
// Compares both tags, picks the word by address bit 2, keeps per-set
// ages and chooses the victim way for a refill. One fetch at a time.

`timescale 1ns/10ps
`include "icache_consts.svh"

module icache_ctrl (
    input  logic                clk,
    input  logic                i_rst_n,
    input  logic                i_fetch_valid,
    input  icache_pkg::addr_t   i_fetch_addr,
    output logic                o_fetch_ready,
    output logic                o_inst_valid,
    output icache_pkg::inst_t   o_inst_data,
    input  logic                i_inst_ready,
    output icache_pkg::index_t  o_index,
    output logic                o_wr_en0,
    output logic                o_wr_en1,
    output icache_pkg::tag_t    o_wr_tag,
    output icache_pkg::line_t   o_wr_line,
    input  icache_pkg::tag_t    i_tag0,
    input  icache_pkg::tag_t    i_tag1,
    input  logic                i_valid0,
    input  logic                i_valid1,
    input  icache_pkg::line_t   i_line0,
    input  icache_pkg::line_t   i_line1,
    output logic                o_refill_req,
    output icache_pkg::addr_t   o_refill_addr,
    input  logic                i_refill_done,
    input  icache_pkg::line_t   i_refill_line
);

    icache_pkg::ctrl_state_t state, state_nxt;
    icache_pkg::addr_t       addr_q;
    icache_pkg::line_t       fill_line_q;
    icache_pkg::line_t       sel_line;
    icache_pkg::tag_t        tag_q;
    icache_pkg::index_t      index_q;
    icache_pkg::age_t        age0 [`ICACHE_SETS];
    icache_pkg::age_t        age1 [`ICACHE_SETS];
    logic                    accept;
    logic                    hit0, hit1;
    logic                    hit_way_q;
    logic                    victim, victim_q;

    assign tag_q   = addr_q[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
    assign index_q = addr_q[`ICACHE_INDEX_W+2:3];

    assign o_fetch_ready = (state == icache_pkg::IDLE);
    assign accept        = i_fetch_valid && o_fetch_ready;

    // the ways latch the incoming index on the accepting edge.
    assign o_index = (state == icache_pkg::IDLE) ? i_fetch_addr[`ICACHE_INDEX_W+2:3] : index_q;

    assign hit0 = i_valid0 && (i_tag0 == tag_q);
    assign hit1 = i_valid1 && (i_tag1 == tag_q);

    // invalid way 0, invalid way 1, then the older way; ties go to way 0.
    always_comb begin
        if (!i_valid0)
            victim = 1'b0;
        else if (!i_valid1)
            victim = 1'b1;
        else
            victim = (age1[index_q] > age0[index_q]);
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n)
            state <= icache_pkg::IDLE;
        else
            state <= state_nxt;
    end

    always_comb begin
        state_nxt = state;
        case (state)
            icache_pkg::IDLE:   if (accept) state_nxt = icache_pkg::LOOKUP;
            icache_pkg::LOOKUP: state_nxt = (hit0 || hit1) ? icache_pkg::HIT : icache_pkg::REFILL;
            icache_pkg::HIT:    if (i_inst_ready) state_nxt = icache_pkg::IDLE;
            icache_pkg::REFILL: if (i_refill_done) state_nxt = icache_pkg::FILL;
            icache_pkg::FILL:   state_nxt = icache_pkg::LOOKUP;
            default:            state_nxt = icache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (accept)
            addr_q <= i_fetch_addr;
        if (state == icache_pkg::LOOKUP) begin
            hit_way_q <= hit1;
            victim_q  <= victim;  // only used when this lookup misses.
        end
        if (i_refill_done)
            fill_line_q <= i_refill_line;
    end

    // way outputs hold in HIT since the index does not change.
    assign sel_line     = hit_way_q ? i_line1 : i_line0;
    assign o_inst_valid = (state == icache_pkg::HIT);
    assign o_inst_data  = addr_q[2] ? sel_line[`ICACHE_LINE_W-1 -: `ICACHE_INST_W]
                                    : sel_line[`ICACHE_INST_W-1:0];

    assign o_refill_req  = (state == icache_pkg::REFILL) && !i_refill_done;
    assign o_refill_addr = {addr_q[`ICACHE_ADDR_W-1:3], 3'b000};

    assign o_wr_en0  = (state == icache_pkg::FILL) && !victim_q;
    assign o_wr_en1  = (state == icache_pkg::FILL) && victim_q;
    assign o_wr_tag  = tag_q;
    assign o_wr_line = fill_line_q;

    // ages grow on each accepted fetch; a hit or a fill makes that way young.
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                age0[s] <= '0;
                age1[s] <= '0;
            end
        end else begin
            if (accept) begin
                for (int s = 0; s < `ICACHE_SETS; s++) begin
                    if (age0[s] != icache_pkg::age_t'(`ICACHE_AGE_MAX))
                        age0[s] <= age0[s] + icache_pkg::age_t'(1);
                    if (age1[s] != icache_pkg::age_t'(`ICACHE_AGE_MAX))
                        age1[s] <= age1[s] + icache_pkg::age_t'(1);
                end
            end
            if (((state == icache_pkg::LOOKUP) && hit0) || o_wr_en0)
                age0[index_q] <= '0;
            if (((state == icache_pkg::LOOKUP) && hit1) || o_wr_en1)
                age1[index_q] <= '0;
        end
    end

endmodule

// ==== icache_pkg.sv ====
// Cache-side types for the instruction cache: address fields, line,
// instruction word, age and the lookup FSM states.

`include "icache_consts.svh"

package icache_pkg;

    typedef logic [`ICACHE_ADDR_W-1:0]  addr_t;
    typedef logic [`ICACHE_TAG_W-1:0]   tag_t;    // addr[63:9].
    typedef logic [`ICACHE_INDEX_W-1:0] index_t;  // addr[8:3].
    typedef logic [`ICACHE_LINE_W-1:0]  line_t;
    typedef logic [`ICACHE_INST_W-1:0]  inst_t;
    typedef logic [`ICACHE_AGE_W-1:0]   age_t;

    // lookup controller states.
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        HIT,
        REFILL,
        FILL
    } ctrl_state_t;

endpackage

// ==== icache_top.sv ====
// Two-way set-associative instruction cache with an AXI4-Lite refill port.
// Fetch side is valid/ready in, valid/ready out; one fetch in flight.

`timescale 1ns/10ps

module icache_top (
    input  logic                    clk,
    input  logic                    i_rst_n,
    input  logic                    i_fetch_valid,
    input  icache_pkg::addr_t       i_fetch_addr,
    output logic                    o_fetch_ready,
    output logic                    o_inst_valid,
    output icache_pkg::inst_t       o_inst_data,
    input  logic                    i_inst_ready,
    output logic                    o_arvalid,
    output axi_lite_pkg::axi_addr_t o_araddr,
    output logic [2:0]              o_arprot,
    input  logic                    i_arready,
    input  logic                    i_rvalid,
    input  axi_lite_pkg::axi_data_t i_rdata,
    input  axi_lite_pkg::axi_resp_t i_rresp,
    output logic                    o_rready
);

    icache_pkg::index_t index;
    icache_pkg::tag_t   wr_tag, tag0, tag1;
    icache_pkg::line_t  wr_line, line0, line1, refill_line;
    icache_pkg::addr_t  refill_addr;
    logic               wr_en0, wr_en1, valid0, valid1;
    logic               refill_req, refill_done;

    icache_ctrl u_ctrl (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_fetch_valid  (i_fetch_valid),
        .i_fetch_addr   (i_fetch_addr),
        .o_fetch_ready  (o_fetch_ready),
        .o_inst_valid   (o_inst_valid),
        .o_inst_data    (o_inst_data),
        .i_inst_ready   (i_inst_ready),
        .o_index        (index),
        .o_wr_en0       (wr_en0),
        .o_wr_en1       (wr_en1),
        .o_wr_tag       (wr_tag),
        .o_wr_line      (wr_line),
        .i_tag0         (tag0),
        .i_tag1         (tag1),
        .i_valid0       (valid0),
        .i_valid1       (valid1),
        .i_line0        (line0),
        .i_line1        (line1),
        .o_refill_req   (refill_req),
        .o_refill_addr  (refill_addr),
        .i_refill_done  (refill_done),
        .i_refill_line  (refill_line)
    );

    icache_way u_way0 (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_index    (index),
        .i_wr_en    (wr_en0),
        .i_wr_tag   (wr_tag),
        .i_wr_line  (wr_line),
        .o_tag      (tag0),
        .o_valid    (valid0),
        .o_line     (line0)
    );

    icache_way u_way1 (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_index    (index),
        .i_wr_en    (wr_en1),
        .i_wr_tag   (wr_tag),
        .i_wr_line  (wr_line),
        .o_tag      (tag1),
        .o_valid    (valid1),
        .o_line     (line1)
    );

    icache_axi_read u_axi_read (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_req      (refill_req),
        .i_req_addr (refill_addr),
        .o_done     (refill_done),
        .o_line     (refill_line),
        .o_arvalid  (o_arvalid),
        .o_araddr   (o_araddr),
        .o_arprot   (o_arprot),
        .i_arready  (i_arready),
        .i_rvalid   (i_rvalid),
        .i_rdata    (i_rdata),
        .i_rresp    (i_rresp),
        .o_rready   (o_rready)
    );

endmodule

// ==== icache_way.sv ====
// One cache way: tag array, data array and valid bits per set.
// Reads are registered; a write in the same cycle is forwarded to the outputs.

`timescale 1ns/10ps
`include "icache_consts.svh"

module icache_way (
    input  logic                clk,
    input  logic                i_rst_n,
    input  icache_pkg::index_t  i_index,
    input  logic                i_wr_en,
    input  icache_pkg::tag_t    i_wr_tag,
    input  icache_pkg::line_t   i_wr_line,
    output icache_pkg::tag_t    o_tag,
    output logic                o_valid,
    output icache_pkg::line_t   o_line
);

    icache_pkg::tag_t       tags  [`ICACHE_SETS];
    icache_pkg::line_t      lines [`ICACHE_SETS];
    logic [`ICACHE_SETS-1:0] valid;

    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            tags[i_index]  <= i_wr_tag;
            lines[i_index] <= i_wr_line;
            o_tag          <= i_wr_tag;   // write-first, so the retry lookup hits.
            o_line         <= i_wr_line;
        end else begin
            o_tag  <= tags[i_index];
            o_line <= lines[i_index];
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            valid   <= '0;
            o_valid <= 1'b0;
        end else if (i_wr_en) begin
            valid[i_index] <= 1'b1;
            o_valid        <= 1'b1;
        end else begin
            o_valid <= valid[i_index];
        end
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the cache testbench with Verilator; exit status follows the result.
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal -f icache.f --top-module tb_icache -Mdir obj_dir \
    && ./obj_dir/Vtb_icache +verilator+error+limit+100 | tee /dev/stderr \
        | grep -qF "Testbench passed" \
    && echo "simulation passed" \
    || { echo "simulation did not pass"; exit 1; }

// ==== tb_icache.sv ====
// Testbench for the two-way instruction cache: AXI4-Lite slave memory,
// fetch stimulus with random back-pressure and a reference model of the
// valid bits, tags and ages that predicts every hit and miss.

`timescale 1ns/10ps
`include "icache_consts.svh"

module tb_icache;

    logic                    clk = 1'b0;
    logic                    i_rst_n;
    logic                    i_fetch_valid;
    icache_pkg::addr_t       i_fetch_addr;
    logic                    o_fetch_ready;
    logic                    o_inst_valid;
    icache_pkg::inst_t       o_inst_data;
    logic                    i_inst_ready;
    logic                    o_arvalid;
    axi_lite_pkg::axi_addr_t o_araddr;
    logic [2:0]              o_arprot;
    logic                    i_arready;
    logic                    i_rvalid;
    axi_lite_pkg::axi_data_t i_rdata;
    axi_lite_pkg::axi_resp_t i_rresp;
    logic                    o_rready;

    int                      seed = 18517;
    int                      ar_count;
    int                      ar_wait;
    int                      r_wait;
    logic                    r_pending;
    axi_lite_pkg::axi_addr_t r_addr;

    // reference copy of the cache state.
    logic                    m_valid [2][`ICACHE_SETS];
    icache_pkg::tag_t        m_tag   [2][`ICACHE_SETS];
    int                      m_age   [2][`ICACHE_SETS];

    icache_top i_icache_top (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_fetch_valid  (i_fetch_valid),
        .i_fetch_addr   (i_fetch_addr),
        .o_fetch_ready  (o_fetch_ready),
        .o_inst_valid   (o_inst_valid),
        .o_inst_data    (o_inst_data),
        .i_inst_ready   (i_inst_ready),
        .o_arvalid      (o_arvalid),
        .o_araddr       (o_araddr),
        .o_arprot       (o_arprot),
        .i_arready      (i_arready),
        .i_rvalid       (i_rvalid),
        .i_rdata        (i_rdata),
        .i_rresp        (i_rresp),
        .o_rready       (o_rready)
    );

    bind icache_top tb_icache_asserts u_asserts (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_fetch_valid  (i_fetch_valid),
        .i_fetch_ready  (o_fetch_ready),
        .i_inst_valid   (o_inst_valid),
        .i_inst_data    (o_inst_data),
        .i_inst_ready   (i_inst_ready),
        .i_arvalid      (o_arvalid),
        .i_araddr       (o_araddr),
        .i_arprot       (o_arprot),
        .i_arready      (i_arready),
        .i_rvalid       (i_rvalid),
        .i_rready       (o_rready)
    );

    always #5 clk = ~clk;

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        return (r % n + n) % n;
    endfunction

    // memory contents: upper word is the address XOR a constant, lower its inversion.
    function automatic axi_lite_pkg::axi_data_t line_for(input axi_lite_pkg::axi_addr_t a);
        return {a[31:0] ^ 32'h5A3C_96E1, ~a[31:0]};
    endfunction

    // one accepted fetch on the model; returns 1 on a hit.
    function automatic bit model_lookup(input icache_pkg::addr_t a);
        icache_pkg::index_t s;
        icache_pkg::tag_t   t;
        int                 w;
        s = a[`ICACHE_INDEX_W+2:3];
        t = a[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
        for (int i = 0; i < `ICACHE_SETS; i++) begin
            for (int k = 0; k < 2; k++) begin
                if (m_age[k][i] < `ICACHE_AGE_MAX)
                    m_age[k][i]++;
            end
        end
        for (int k = 0; k < 2; k++) begin
            if (m_valid[k][s] && m_tag[k][s] == t) begin
                m_age[k][s] = 0;
                return 1'b1;
            end
        end
        if (!m_valid[0][s])
            w = 0;
        else if (!m_valid[1][s])
            w = 1;
        else
            w = (m_age[1][s] > m_age[0][s]) ? 1 : 0;  // tie keeps way 0 as victim.
        m_valid[w][s] = 1'b1;
        m_tag[w][s]   = t;
        m_age[w][s]   = 0;
        return 1'b0;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("ERROR %0t: %s", $time, msg);
        $display("Testbench failed");
        $fatal(1, "value mismatch");
    endtask

    task automatic abort_timeout(input string what);
        $display("timeout at %0t while waiting for %s", $time, what);
        $display("Testbench failed");
        $fatal(1, "timeout");
    endtask

    // AXI4-Lite slave with random ARREADY and RVALID delays, one beat per read.
    always @(negedge clk) begin
        i_arready = 1'b0;
        i_rvalid  = 1'b0;
        if (!i_rst_n) begin
            r_pending = 1'b0;
            ar_wait   = rand_below(6);
        end else if (r_pending) begin
            if (r_wait == 0) begin
                i_rvalid  = 1'b1;
                i_rdata   = line_for(r_addr);
                r_pending = 1'b0;
                ar_wait   = rand_below(6);
            end else begin
                r_wait--;
            end
        end else if (o_arvalid) begin
            if (ar_wait == 0) begin
                i_arready = 1'b1;
                r_addr    = o_araddr;
                r_pending = 1'b1;
                r_wait    = rand_below(6);
                ar_count++;
            end else begin
                ar_wait--;
            end
        end
    end

    always @(negedge clk) begin
        if (i_icache_top.u_asserts.fail_count != 0) begin
            $display("a protocol or timing assertion failed at %0t", $time);
            $display("Testbench failed");
            $fatal(1, "assertion failure");
        end
    end

    task automatic fetch_and_check(input icache_pkg::addr_t a);
        bit                      exp_hit;
        int                      ar_before;
        int                      t;
        axi_lite_pkg::axi_data_t exp_line;
        icache_pkg::inst_t       exp_inst;
        exp_line = line_for({a[`ICACHE_ADDR_W-1:3], 3'b000});
        exp_inst = a[2] ? exp_line[63:32] : exp_line[31:0];
        t = 0;
        while (!o_fetch_ready) begin
            @(negedge clk);
            t++;
            if (t > 50)
                abort_timeout("o_fetch_ready");
        end
        exp_hit       = model_lookup(a);
        ar_before     = ar_count;
        i_fetch_valid = 1'b1;
        i_fetch_addr  = a;
        @(negedge clk);
        i_fetch_valid = 1'b0;
        t = 0;
        while (!o_inst_valid) begin
            @(negedge clk);
            t++;
            if (t > 100)
                abort_timeout("o_inst_valid");
        end
        repeat (rand_below(6)) @(negedge clk);  // hold the response back.
        assert (o_inst_data == exp_inst)
            else report_mismatch($sformatf("addr %h gave %h, expected %h",
                                           a, o_inst_data, exp_inst));
        assert ((ar_count - ar_before) == (exp_hit ? 0 : 1))
            else report_mismatch($sformatf("addr %h caused %0d AR, expected %0d",
                                           a, ar_count - ar_before, exp_hit ? 0 : 1));
        i_inst_ready = 1'b1;
        @(negedge clk);
        i_inst_ready = 1'b0;
    endtask

    initial begin
        icache_pkg::addr_t a;
        i_rst_n       = 1'b0;
        i_fetch_valid = 1'b0;
        i_fetch_addr  = '0;
        i_inst_ready  = 1'b0;
        i_arready     = 1'b0;
        i_rvalid      = 1'b0;
        i_rdata       = '0;
        i_rresp       = '0;
        ar_count      = 0;
        ar_wait       = 0;
        r_wait        = 0;
        r_pending     = 1'b0;
        for (int i = 0; i < `ICACHE_SETS; i++) begin
            for (int k = 0; k < 2; k++) begin
                m_valid[k][i] = 1'b0;
                m_tag[k][i]   = '0;
                m_age[k][i]   = 0;
            end
        end
        repeat (2) @(negedge clk);
        i_rst_n = 1'b1;
        @(negedge clk);

        // cold miss, then the other word of the same line.
        fetch_and_check(64'h0000_0000_8000_1040);
        fetch_and_check(64'h0000_0000_8000_1044);

        // tags A, B, C in set 5: A B A C B A.
        fetch_and_check(64'h0000_0000_0000_0228);
        fetch_and_check(64'h0000_0000_0000_042C);
        fetch_and_check(64'h0000_0000_0000_0228);
        fetch_and_check(64'h0000_0000_0000_0628);
        fetch_and_check(64'h0000_0000_0000_042C);
        fetch_and_check(64'h0000_0000_0000_0228);

        // random mix of 4 tags over 3 sets.
        for (int n = 0; n < 60; n++) begin
            a = 64'h4000_0000 + (64'(rand_below(4)) << 9) + (64'(rand_below(3)) << 3)
                + (64'(rand_below(2)) << 2);
            fetch_and_check(a);
        end

        repeat (2) @(negedge clk);
        if (i_icache_top.u_asserts.fail_count != 0) begin
            $display("a protocol or timing assertion failed");
            $display("Testbench failed");
            $fatal(1, "assertion failure");
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

// ==== tb_icache_asserts.sv ====
// Concurrent protocol and timing checks for the instruction cache.
// Bound into icache_top from the testbench; fail_count counts failures.

`timescale 1ns/10ps
`include "icache_consts.svh"

module tb_icache_asserts (
    input  logic                    clk,
    input  logic                    i_rst_n,
    input  logic                    i_fetch_valid,
    input  logic                    i_fetch_ready,
    input  logic                    i_inst_valid,
    input  icache_pkg::inst_t       i_inst_data,
    input  logic                    i_inst_ready,
    input  logic                    i_arvalid,
    input  axi_lite_pkg::axi_addr_t i_araddr,
    input  logic [2:0]              i_arprot,
    input  logic                    i_arready,
    input  logic                    i_rvalid,
    input  logic                    i_rready
);

    int   fail_count = 0;
    logic accept;
    logic ar_seen;

    assign accept = i_fetch_valid && i_fetch_ready;

    // an AR handshake since the last accepted fetch marks a miss.
    always_ff @(posedge clk) begin
        if (!i_rst_n || accept)
            ar_seen <= 1'b0;
        else if (i_arvalid && i_arready)
            ar_seen <= 1'b1;
    end

    a_reset_idle: assert property (@(posedge clk)
        !i_rst_n |=> !i_inst_valid && !i_arvalid && !i_rready && i_fetch_ready)
        else begin fail_count++; $error("outputs not idle after reset"); end

    // nothing comes back in the lookup cycle itself.
    a_no_early: assert property (@(posedge clk) disable iff (!i_rst_n)
        accept |=> !i_inst_valid)
        else begin fail_count++; $error("response during lookup"); end

    // a response with no refill behind it comes a fixed time after the accept.
    a_hit_lat: assert property (@(posedge clk) disable iff (!i_rst_n)
        $rose(i_inst_valid) && !ar_seen |-> $past(accept, `ICACHE_HIT_LAT))
        else begin fail_count++; $error("hit latency wrong"); end

    a_resp_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_inst_valid && !i_inst_ready |=> i_inst_valid && $stable(i_inst_data))
        else begin fail_count++; $error("response dropped or changed under back-pressure"); end

    a_busy: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_inst_valid |-> !i_fetch_ready)
        else begin fail_count++; $error("fetch accepted with a response pending"); end

    a_ar_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_arvalid && !i_arready |=> i_arvalid && $stable(i_araddr))
        else begin fail_count++; $error("AR dropped or changed before ARREADY"); end

    a_ar_align: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_arvalid |-> i_araddr[2:0] == 3'b000)
        else begin fail_count++; $error("ARADDR not line aligned"); end

    a_ar_prot: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_arvalid |-> i_arprot == 3'b000)
        else begin fail_count++; $error("ARPROT not zero"); end

    a_r_ready: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_arvalid && i_arready |=> i_rready)
        else begin fail_count++; $error("RREADY low after address phase"); end

    a_r_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_rready && !i_rvalid |=> i_rready)
        else begin fail_count++; $error("RREADY dropped before the R beat"); end

    a_one_ar: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_rready |-> !i_arvalid)
        else begin fail_count++; $error("second AR during data phase"); end

endmodule
